// File: Makefile
VERILATOR  ?= verilator
TOP        := div_unit_tb
FILELIST   := project.f
BUILD_DIR  := obj_dir
VFLAGS     := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing -Wall
LOG        := sim.log
PASS_TEXT  := SIMULATION PASSED
SOURCES    := $(wildcard source/*.sv source/*.svh tests/*.sv tests/*.mem)
BIN        := $(BUILD_DIR)/V$(TOP)

.PHONY: all run lint clean

all: run

$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: project.f
+incdir+source
source/div_pkg.sv
source/div_decode.sv
source/div_digit_step.sv
source/div_execute.sv
source/div_result.sv
source/div_unit.sv
tests/div_unit_tb.sv

// File: source/div_decode.sv
`timescale 1ns/1ns
`include "div_macros.svh"

module div_decode (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   order,
    input  div_pkg::div_op_e       op,
    input  logic [`DIV_XLEN-1:0]   rs1,
    input  logic [`DIV_XLEN-1:0]   rs2,
    output logic                   valid,
    output div_pkg::div_operands_t operands,
    output div_pkg::div_ctrl_t     ctrl
);

    logic is_signed;
    logic rs1_neg;
    logic rs2_neg;
    logic rs2_zero;

    always_comb begin
        is_signed = (op == div_pkg::OP_DIV) || (op == div_pkg::OP_REM);
        rs1_neg   = is_signed && rs1[`DIV_XLEN-1];
        rs2_neg   = is_signed && rs2[`DIV_XLEN-1];
        rs2_zero  = (rs2 == '0);
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid <= 1'b0;
        end else begin
            valid <= order;
        end
    end

    // magnitudes go to the unsigned core, signs become sideband
    always_ff @(posedge clk) begin
        if (order) begin
            operands.dividend <= rs1_neg ? -rs1 : rs1;
            operands.divisor  <= rs2_neg ? -rs2 : rs2;
            ctrl.rem_sel      <= (op == div_pkg::OP_REM) || (op == div_pkg::OP_REMU);
            // divide by zero keeps the all-ones quotient
            ctrl.neg_quot     <= (rs1_neg != rs2_neg) && !rs2_zero;
            ctrl.neg_rem      <= rs1_neg;
        end
    end

    a_op_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        order |-> !$isunknown(op)
    ) else $error("div_decode: op unknown while order is high");

endmodule

// File: source/div_digit_step.sv
`timescale 1ns/1ns
`include "div_macros.svh"

module div_digit_step (
    input  div_pkg::div_partial_t   partial_in,
    input  div_pkg::div_multiples_t multiples,
    output div_pkg::div_partial_t   partial_out
);

    localparam int MULT_W = `DIV_XLEN + `DIV_DIGIT_BITS;
    localparam int MULT_N = (1 << `DIV_DIGIT_BITS) - 1;
    localparam int LOW_W  = `DIV_XLEN - `DIV_DIGIT_BITS;

    logic [MULT_W-1:0]          top;
    logic [MULT_W-1:0]          rest;
    logic [`DIV_DIGIT_BITS-1:0] digit;

    always_comb begin
        // partial remainder plus the next dividend digit
        top   = partial_in.window[2*`DIV_XLEN-1:LOW_W];
        rest  = top;
        digit = '0;
        // ascending scan, the last hit is the largest multiple that fits
        for (int i = 1; i <= MULT_N; i++) begin
            if (top >= multiples[i-1]) begin
                digit = `DIV_DIGIT_BITS'(i);
                rest  = top - multiples[i-1];
            end
        end
    end

    always_comb begin
        partial_out.quotient = {partial_in.quotient[LOW_W-1:0], digit};
        // rest fits in XLEN bits once a multiple is taken
        partial_out.window   = {rest[`DIV_XLEN-1:0],
                                partial_in.window[LOW_W-1:0],
                                {`DIV_DIGIT_BITS{1'b0}}};
    end

endmodule

// File: source/div_execute.sv
`timescale 1ns/1ns
`include "div_macros.svh"

module div_execute (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   valid_in,
    input  div_pkg::div_operands_t operands,
    input  div_pkg::div_ctrl_t     ctrl_in,
    output logic                   valid_out,
    output div_pkg::div_qr_t       result,
    output div_pkg::div_ctrl_t     ctrl_out
);

    localparam int MULT_W = `DIV_XLEN + `DIV_DIGIT_BITS;
    localparam int MULT_N = (1 << `DIV_DIGIT_BITS) - 1;

    div_pkg::div_multiples_t seed_mult;
    div_pkg::div_partial_t   part_in  [`DIV_DIGITS];
    div_pkg::div_partial_t   part_out [`DIV_DIGITS];
    div_pkg::div_multiples_t mult     [`DIV_DIGITS];
    div_pkg::div_ctrl_t      ctrl     [`DIV_DIGITS];
    logic                    vld      [`DIV_DIGITS];
    logic [MULT_W-1:0]       last_divisor;

    // divisor times 1..15, widened so that 15x cannot overflow
    always_comb begin
        for (int i = 0; i < MULT_N; i++) begin
            seed_mult[i] = {{`DIV_DIGIT_BITS{1'b0}}, operands.divisor} * MULT_W'(i + 1);
        end
    end

    for (genvar l = 0; l < `DIV_DIGITS; l++) begin : g_step
        if (l == 0) begin : g_seed
            assign part_in[l] = '{quotient: '0,
                                  window: {{`DIV_XLEN{1'b0}}, operands.dividend}};
            assign mult[l]    = seed_mult;
            assign ctrl[l]    = ctrl_in;
            assign vld[l]     = valid_in;
        end else if (l % `DIV_STAGE_PERIOD == 0) begin : g_reg
            // stage boundary, everything moves together
            div_pkg::div_partial_t   part_q;
            div_pkg::div_multiples_t mult_q;
            div_pkg::div_ctrl_t      ctrl_q;
            logic                    vld_q;

            always_ff @(posedge clk) begin
                if (!rst_n) begin
                    vld_q <= 1'b0;
                end else begin
                    vld_q <= vld[l-1];
                end
            end

            always_ff @(posedge clk) begin
                part_q <= part_out[l-1];
                mult_q <= mult[l-1];
                ctrl_q <= ctrl[l-1];
            end

            assign part_in[l] = part_q;
            assign mult[l]    = mult_q;
            assign ctrl[l]    = ctrl_q;
            assign vld[l]     = vld_q;
        end else begin : g_chain
            assign part_in[l] = part_out[l-1];
            assign mult[l]    = mult[l-1];
            assign ctrl[l]    = ctrl[l-1];
            assign vld[l]     = vld[l-1];
        end

        div_digit_step u_step (
            .partial_in  (part_in[l]),
            .multiples   (mult[l]),
            .partial_out (part_out[l])
        );
    end

    // output register after the last digit
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_out <= 1'b0;
        end else begin
            valid_out <= vld[`DIV_DIGITS-1];
        end
    end

    always_ff @(posedge clk) begin
        result.quotient  <= part_out[`DIV_DIGITS-1].quotient;
        result.remainder <= part_out[`DIV_DIGITS-1].window[2*`DIV_XLEN-1:`DIV_XLEN];
        ctrl_out         <= ctrl[`DIV_DIGITS-1];
    end

    // divisor as seen by the final step, one cycle before valid_out
    assign last_divisor = mult[`DIV_DIGITS-1][0];

    a_rem_below_divisor: assert property (
        @(posedge clk) disable iff (!rst_n)
        valid_out && ($past(last_divisor) != '0)
            |-> MULT_W'(result.remainder) < $past(last_divisor)
    ) else $error("div_execute: remainder not below divisor");

endmodule

// File: source/div_macros.svh
`ifndef DIV_MACROS_SVH
`define DIV_MACROS_SVH

// operand and result width
`define DIV_XLEN 32

// quotient bits resolved per digit step (radix 16)
`define DIV_DIGIT_BITS 4

// digit steps per division, DIV_XLEN / DIV_DIGIT_BITS
`define DIV_DIGITS 8

// digit steps between pipeline registers
`define DIV_STAGE_PERIOD 3

// cycles from order to done
`define DIV_LATENCY 5

`endif

// File: source/div_pkg.sv
`include "div_macros.svh"

package div_pkg;

    // encodings follow funct3[1:0] of the M extension divides
    typedef enum logic [1:0] {
        OP_DIV  = 2'b00,
        OP_DIVU = 2'b01,
        OP_REM  = 2'b10,
        OP_REMU = 2'b11
    } div_op_e;

    typedef struct packed {
        logic [`DIV_XLEN-1:0] dividend;
        logic [`DIV_XLEN-1:0] divisor;
    } div_operands_t;

    // sideband that rides along with the data
    typedef struct packed {
        logic rem_sel;
        logic neg_quot;
        logic neg_rem;
    } div_ctrl_t;

    // window holds the partial remainder on top, unused dividend bits below
    typedef struct packed {
        logic [`DIV_XLEN-1:0]   quotient;
        logic [2*`DIV_XLEN-1:0] window;
    } div_partial_t;

    // entry i is divisor * (i + 1)
    typedef logic [(1 << `DIV_DIGIT_BITS)-2:0][`DIV_XLEN+`DIV_DIGIT_BITS-1:0] div_multiples_t;

    typedef struct packed {
        logic [`DIV_XLEN-1:0] quotient;
        logic [`DIV_XLEN-1:0] remainder;
    } div_qr_t;

endpackage

// File: source/div_result.sv
`timescale 1ns/1ns
`include "div_macros.svh"

module div_result (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 valid_in,
    input  div_pkg::div_qr_t     result,
    input  div_pkg::div_ctrl_t   ctrl,
    output logic                 done,
    output logic [`DIV_XLEN-1:0] rd
);

    logic [`DIV_XLEN-1:0] quot_signed;
    logic [`DIV_XLEN-1:0] rem_signed;

    // put the signs back on the unsigned results
    always_comb begin
        quot_signed = ctrl.neg_quot ? -result.quotient : result.quotient;
        rem_signed  = ctrl.neg_rem ? -result.remainder : result.remainder;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            done <= 1'b0;
        end else begin
            done <= valid_in;
        end
    end

    always_ff @(posedge clk) begin
        if (valid_in) begin
            rd <= ctrl.rem_sel ? rem_signed : quot_signed;
        end
    end

    // a quotient that gets negated always fits the signed range
    a_neg_quot_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        valid_in && ctrl.neg_quot
            |-> (result.quotient <= {1'b1, {(`DIV_XLEN-1){1'b0}}})
    ) else $error("div_result: negated quotient outside the signed range");

endmodule

// File: source/div_unit.sv
`timescale 1ns/1ns
`include "div_macros.svh"

module div_unit (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 order,
    input  div_pkg::div_op_e     op,
    input  logic [`DIV_XLEN-1:0] rs1,
    input  logic [`DIV_XLEN-1:0] rs2,
    output logic                 done,
    output logic [`DIV_XLEN-1:0] rd
);

    logic                   dec_valid;
    div_pkg::div_operands_t dec_operands;
    div_pkg::div_ctrl_t     dec_ctrl;
    logic                   exe_valid;
    div_pkg::div_qr_t       exe_result;
    div_pkg::div_ctrl_t     exe_ctrl;

    div_decode u_decode (
        .clk      (clk),
        .rst_n    (rst_n),
        .order    (order),
        .op       (op),
        .rs1      (rs1),
        .rs2      (rs2),
        .valid    (dec_valid),
        .operands (dec_operands),
        .ctrl     (dec_ctrl)
    );

    // unsigned core, three cycles
    div_execute u_execute (
        .clk       (clk),
        .rst_n     (rst_n),
        .valid_in  (dec_valid),
        .operands  (dec_operands),
        .ctrl_in   (dec_ctrl),
        .valid_out (exe_valid),
        .result    (exe_result),
        .ctrl_out  (exe_ctrl)
    );

    div_result u_result (
        .clk      (clk),
        .rst_n    (rst_n),
        .valid_in (exe_valid),
        .result   (exe_result),
        .ctrl     (exe_ctrl),
        .done     (done),
        .rd       (rd)
    );

endmodule

// File: tests/div_tests.mem
// op rs1 rs2 expected_rd gap, hex, one vector per line
// op 0 DIV, 1 DIVU, 2 REM, 3 REMU; gap is idle cycles after the request
1 00000064 00000007 0000000e 0
3 00000064 00000007 00000002 2
1 00000005 00000009 00000000 0
3 00000005 00000009 00000005 0
1 ffffffff 00000001 ffffffff 1
1 ffffffff 00010000 0000ffff 0
3 ffffffff 00010000 0000ffff 0
1 12345678 00001234 00010004 0
3 12345678 00001234 00000da8 3
1 fffffffe ffffffff 00000000 0
0 fffffff9 00000002 fffffffd 0
2 fffffff9 00000002 ffffffff 0
0 00000007 fffffffe fffffffd 0
2 00000007 fffffffe 00000001 1
0 fffffff9 fffffffe 00000003 0
2 fffffff9 fffffffe ffffffff 0
0 00000007 00000002 00000003 0
2 00000007 00000002 00000001 6
0 00001234 00000000 ffffffff 0
1 00001234 00000000 ffffffff 0
2 fffffff9 00000000 fffffff9 0
3 87654321 00000000 87654321 2
0 80000000 ffffffff 80000000 0
2 80000000 ffffffff 00000000 0

// File: tests/div_unit_tb.sv
`timescale 1ns/1ns
`include "div_macros.svh"

module div_unit_tb;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 4;
    localparam int MAX_VECTORS  = 64;
    localparam int FIELDS       = 5;
    // order driven on a rising edge, done rises DIV_LATENCY edges later, checked at a falling edge
    localparam int LATENCY_TIME = `DIV_LATENCY * CLK_PERIOD + CLK_PERIOD / 2;

    typedef struct packed {
        logic [15:0]          index;
        logic [1:0]           op;
        logic [`DIV_XLEN-1:0] expected;
        logic [63:0]          issued_at;
    } pending_t;

    logic                 clk;
    logic                 rst_n;
    logic                 order;
    div_pkg::div_op_e     op;
    logic [`DIV_XLEN-1:0] rs1;
    logic [`DIV_XLEN-1:0] rs2;
    logic                 done;
    logic [`DIV_XLEN-1:0] rd;

    // five words per vector: op, rs1, rs2, expected rd, idle gap
    logic [31:0] vec_mem [MAX_VECTORS*FIELDS];
    pending_t    pending [$];
    int          vector_count;
    int          total_gaps;
    int          pass_count;
    int          fail_count;
    int          other_errors;
    logic        loaded;

    div_unit UUT (
        .clk   (clk),
        .rst_n (rst_n),
        .order (order),
        .op    (op),
        .rs1   (rs1),
        .rs2   (rs2),
        .done  (done),
        .rd    (rd)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // op words above 3 are still the fill pattern
    function automatic int count_vectors();
        int n;
        n = 0;
        while (n < MAX_VECTORS && vec_mem[n*FIELDS] < 4) begin
            n++;
        end
        return n;
    endfunction

    task automatic issue_vector(input int idx);
        int       base;
        pending_t entry;
        base            = idx * FIELDS;
        order          <= 1'b1;
        op             <= div_pkg::div_op_e'(vec_mem[base][1:0]);
        rs1            <= vec_mem[base+1];
        rs2            <= vec_mem[base+2];
        entry.index     = 16'(idx);
        entry.op        = vec_mem[base][1:0];
        entry.expected  = vec_mem[base+3];
        entry.issued_at = $time;
        pending.push_back(entry);
        @(posedge clk);
        if (vec_mem[base+4] != 0) begin
            order <= 1'b0;
            repeat (vec_mem[base+4]) @(posedge clk);
        end
    endtask

    task automatic check_result();
        pending_t         entry;
        logic [63:0]      elapsed;
        logic             ok;
        div_pkg::div_op_e op_name;
        if (pending.size() == 0) begin
            other_errors++;
            $display("done went high at %0t ns with no request outstanding", $time);
        end else begin
            entry   = pending.pop_front();
            elapsed = $time - entry.issued_at;
            op_name = div_pkg::div_op_e'(entry.op);
            ok      = 1'b1;
            if (rd !== entry.expected) begin
                $display("Error at %0t ns: rd expected %h actual %h",
                         $time, entry.expected, rd);
                ok = 1'b0;
            end
            if (elapsed != 64'(LATENCY_TIME)) begin
                $display("test %0d: done came %0d ns after order was driven, expected %0d ns",
                         entry.index, elapsed, LATENCY_TIME);
                ok = 1'b0;
            end
            if (ok) begin
                pass_count++;
            end else begin
                fail_count++;
            end
            $display("test %0d %s: %s", entry.index, op_name.name(), ok ? "pass" : "fail");
        end
    endtask

    // falling edge keeps sampling away from the NBA updates
    always @(negedge clk) begin
        if (rst_n === 1'b1 && done === 1'b1) begin
            check_result();
        end
    end

    initial begin
        rst_n        = 1'b0;
        order        = 1'b0;
        op           = div_pkg::OP_DIV;
        rs1          = '0;
        rs2          = '0;
        pass_count   = 0;
        fail_count   = 0;
        other_errors = 0;
        total_gaps   = 0;
        loaded       = 1'b0;
        for (int i = 0; i < MAX_VECTORS * FIELDS; i++) begin
            vec_mem[i] = {16'hdead, 16'(i)};
        end
        $readmemh("tests/div_tests.mem", vec_mem);
        vector_count = count_vectors();
        for (int i = 0; i < vector_count; i++) begin
            total_gaps += int'(vec_mem[i*FIELDS+4]);
        end
        loaded = 1'b1;

        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        for (int i = 0; i < vector_count; i++) begin
            issue_vector(i);
        end
        order <= 1'b0;

        // drain what is still in flight
        for (int c = 0; c < `DIV_LATENCY + 3 && pending.size() != 0; c++) begin
            @(posedge clk);
        end
        repeat (2) @(posedge clk);

        if (pending.size() != 0) begin
            other_errors++;
            $display("%0d results never arrived", pending.size());
        end
        if (vector_count == 0) begin
            other_errors++;
            $display("no test vectors were read from the data file");
        end
        $display("tests passed %0d, failed %0d, other errors %0d",
                 pass_count, fail_count, other_errors);
        if (fail_count == 0 && other_errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    initial begin
        wait (loaded === 1'b1);
        #(CLK_PERIOD * (vector_count + total_gaps + `DIV_LATENCY + 20));
        $display("watchdog expired with %0d results still pending", pending.size());
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule
